//--- dv/tb_pcie_ob_tasks.svh
// typed compares, one per kind of result
task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        mismatches++;
        $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_hdr(input string name, input wr_hdr_t got, input wr_hdr_t exp);
    if (got !== exp) begin
        mismatches++;
        $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
        mismatches++;
        $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        mismatches++;
        $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic fail_note(input string what);
    other_errs++;
    $display("ERROR %s at %0t", what, $time);
endtask

task automatic print_counts();
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
endtask

// all drivers start and end on a falling edge
task automatic send_aw(input logic [`OB_ADDR_W-1:0] addr, input axi_len_t len);
    aw_valid = 1'b1;
    aw_addr  = addr;
    aw_len   = len;
    while (!aw_ready) @(negedge ob_clk);
    @(negedge ob_clk);
    aw_valid = 1'b0;
endtask

task automatic send_w(input int beats, input be_t first_strb, input be_t last_strb);
    int    i;
    data_t d;
    exp_data.delete();
    for (i = 0; i < beats; i++) begin
        d = $urandom;
        exp_data.push_back(d);
        w_valid = 1'b1;
        w_data  = d;
        w_strb  = (i == 0) ? first_strb : ((i == beats - 1) ? last_strb : 4'b1111);
        w_last  = (i == beats - 1);
        while (!w_ready) @(negedge ob_clk);
        @(negedge ob_clk);
    end
    w_valid = 1'b0;
    w_last  = 1'b0;
endtask

// gathers dwords until tx_last, with random stalls if asked
task automatic collect_tlp(input logic stall);
    logic done;
    got_dw.delete();
    done = 1'b0;
    while (!done) begin
        tx_ready = stall ? ($urandom % 3 != 0) : 1'b1;
        if (tx_valid && tx_ready) begin
            got_dw.push_back(tx_data);
            done = tx_last;
        end
        @(negedge ob_clk);
    end
    tx_ready = 1'b0;
endtask

task automatic check_tlp(input logic [`OB_ADDR_W-1:0] addr, input int beats,
                         input be_t first_strb, input be_t last_strb);
    wr_hdr_t got;
    wr_hdr_t exp;
    req_id_t rid;
    data_t   dw0;
    data_t   dw1;
    data_t   dw2;
    int      i;
    if (got_dw.size() != beats + 3) begin
        fail_note($sformatf("TLP carried %0d dwords, %0d expected", got_dw.size(), beats + 3));
        return;
    end
    dw0          = got_dw[0];
    dw1          = got_dw[1];
    dw2          = got_dw[2];
    rid          = {bus_number, dev_number, func_number};
    exp.addr     = addr[`OB_ADDR_W-1:2];
    exp.len      = tlp_len_t'(beats);
    exp.be_first = first_strb;
    exp.be_last  = (beats == 1) ? 4'b0000 : last_strb;   // single dword, no last BE
    got.addr     = dw2[31:2];
    got.len      = dw0[9:0];
    got.be_first = dw1[3:0];
    got.be_last  = dw1[7:4];
    check_hdr("tlp_hdr", got, exp);
    check_data("tlp_dw0_fmt_type", dw0 & 32'hffff_fc00, 32'h4000_0000);  // MWr 3DW
    check_data("tlp_dw1_id_tag", dw1 & 32'hffff_ff00, {rid, 16'h0000});
    check_data("tlp_dw2_low", dw2 & 32'h0000_0003, 32'h0000_0000);
    for (i = 0; i < beats; i++) begin
        check_data($sformatf("tlp_data[%0d]", i), got_dw[i + 3], exp_data[i]);
    end
endtask

task automatic wait_resp(output axi_resp_t resp);
    b_ready = 1'b1;
    while (!b_valid) @(negedge ob_clk);
    resp = b_resp;
    @(negedge ob_clk);
    b_ready = 1'b0;
endtask

task automatic write_burst(input logic [`OB_ADDR_W-1:0] addr, input int beats,
                           input be_t first_strb, input be_t last_strb, input logic stall);
    axi_resp_t resp;
    send_aw(addr, axi_len_t'(beats - 1));
    check_flag("wr_busy", wr_busy, 1'b1);   // burst accepted, bridge now busy
    send_w(beats, first_strb, last_strb);
    collect_tlp(stall);
    check_tlp(addr, beats, first_strb, last_strb);
    wait_resp(resp);
    check_resp("b_resp", resp, OKAY);
endtask

//--- dv/tb_pcie_ob_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_ob_settings.svh"

module tb_pcie_ob_bridge;
    import pcie_ob_pkg::*;

    // beats over all tests, then 200 cycles of slack per test
    localparam int TEST_BEATS     = 1 + 16 + 16 + 4 + 4 + 8 + 12;
    localparam int TIMEOUT_CYCLES = TEST_BEATS + 6 * 200;

    logic                  ob_clk;
    logic                  rst_n;
    logic                  aw_valid;
    logic                  aw_ready;
    logic [`OB_ADDR_W-1:0] aw_addr;
    axi_len_t              aw_len;
    logic                  w_valid;
    logic                  w_ready;
    data_t                 w_data;
    be_t                   w_strb;
    logic                  w_last;
    logic                  b_valid;
    logic                  b_ready;
    axi_resp_t             b_resp;
    logic                  wr_disable;
    logic                  wr_busy;
    logic                  dma_en;
    logic [7:0]            bus_number;
    logic [4:0]            dev_number;
    logic [2:0]            func_number;
    fc_ph_t                fc_ph;
    fc_pd_t                fc_pd;
    logic                  tx_valid;
    logic                  tx_ready;
    data_t                 tx_data;
    logic                  tx_last;

    int    mismatches;
    int    other_errs;
    int    cycles;
    int    tx_busy_cycles;      // cycles with tx_valid high
    data_t exp_data[$];         // beats sent on W, in order
    data_t got_dw[$];           // dwords of the last TLP

    `include "tb_pcie_ob_tasks.svh"

    pcie_ob_bridge DUT (.*);

    initial begin
        ob_clk = 1'b0;
        forever #5 ob_clk = ~ob_clk;
    end

    always_ff @(posedge ob_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy_cycles <= 0;
        end else if (tx_valid) begin
            tx_busy_cycles <= tx_busy_cycles + 1;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ob_clk);
            cycles++;
        end
        $display("timeout: tests still running after %0d cycles", cycles);
        print_counts();
        $display("TEST FAILED");
        $finish;
    end

    task automatic credit_stall_write();
        int        seen;
        axi_resp_t resp;
        fc_pd = 12'd3;                  // 16 dwords need 4 data credits
        send_aw(32'h0004_0000, 4'd15);
        send_w(16, 4'b1111, 4'b1111);
        seen = tx_busy_cycles;
        repeat (50) @(negedge ob_clk);
        if (tx_busy_cycles != seen) begin
            fail_note("tx_valid rose while posted data credits were short");
        end
        fc_pd = 12'd64;
        collect_tlp(1'b0);
        check_tlp(32'h0004_0000, 16, 4'b1111, 4'b1111);
        wait_resp(resp);
        check_resp("b_resp", resp, OKAY);
    endtask

    task automatic dma_off_write();
        int        seen;
        axi_resp_t resp;
        dma_en = 1'b0;
        seen   = tx_busy_cycles;
        send_aw(32'h0000_8000, 4'd3);
        send_w(4, 4'b1111, 4'b1111);
        wait_resp(resp);
        check_resp("b_resp", resp, SLVERR);
        if (tx_busy_cycles != seen) begin
            fail_note("tx_valid rose for a burst dropped with bus mastering off");
        end
        dma_en = 1'b1;
        write_burst(32'h0000_8010, 4, 4'b1000, 4'b0001, 1'b0);
    endtask

    task automatic disable_blocks_aw();
        wr_disable = 1'b1;
        repeat (3) @(negedge ob_clk);   // two sync flops
        check_flag("aw_ready", aw_ready, 1'b0);
        aw_valid = 1'b1;
        aw_addr  = 32'h0010_0020;
        aw_len   = 4'd7;
        repeat (20) begin
            @(negedge ob_clk);
            check_flag("aw_ready", aw_ready, 1'b0);
            check_flag("wr_busy", wr_busy, 1'b0);
        end
        wr_disable = 1'b0;
        write_burst(32'h0010_0020, 8, 4'b1111, 4'b0111, 1'b0);  // AW still pending
    endtask

    initial begin
        void'($urandom(32'h4f7b));
        mismatches  = 0;
        other_errs  = 0;
        rst_n       = 1'b0;
        aw_valid    = 1'b0;
        aw_addr     = '0;
        aw_len      = '0;
        w_valid     = 1'b0;
        w_data      = '0;
        w_strb      = '0;
        w_last      = 1'b0;
        b_ready     = 1'b0;
        wr_disable  = 1'b0;
        dma_en      = 1'b1;
        bus_number  = 8'h3a;
        dev_number  = 5'h05;
        func_number = 3'h2;
        fc_ph       = 8'd8;
        fc_pd       = 12'd64;
        tx_ready    = 1'b0;
        repeat (5) @(negedge ob_clk);
        rst_n = 1'b1;
        @(negedge ob_clk);
        check_flag("aw_ready", aw_ready, 1'b1);
        check_flag("wr_busy", wr_busy, 1'b0);
        check_flag("b_valid", b_valid, 1'b0);
        check_flag("tx_valid", tx_valid, 1'b0);

        write_burst(32'h0000_1a04, 1, 4'b0110, 4'b0110, 1'b0);
        write_burst(32'h0002_0040, 16, 4'b1100, 4'b0011, 1'b0);
        credit_stall_write();
        dma_off_write();
        disable_blocks_aw();
        write_burst(32'h00a0_0100, 12, 4'b1110, 4'b0011, 1'b1);

        print_counts();
        if (mismatches + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pcie_ob_bridge.f
+incdir+rtl
rtl/pcie_ob_pkg.sv
rtl/ob_wr_beat_fifo.sv
rtl/ob_wr_cmd.sv
rtl/ob_mwr_tlp.sv
rtl/pcie_ob_bridge.sv
dv/tb_pcie_ob_bridge.sv
+incdir+dv

//--- rtl/ob_mwr_tlp.sv
`timescale 1ns/1ps
`default_nettype none

module ob_mwr_tlp (
    input  logic                 ob_clk,
    input  logic                 rst_n,
    // header from the command unit
    input  logic                 hdr_valid,
    output logic                 hdr_ready,
    input  pcie_ob_pkg::wr_hdr_t hdr,
    // beat FIFO
    output logic                 pop,
    input  pcie_ob_pkg::data_t   pop_data,
    input  logic                 fifo_empty,
    // link partner credits and our ID
    input  pcie_ob_pkg::fc_ph_t  fc_ph,
    input  pcie_ob_pkg::fc_pd_t  fc_pd,
    input  logic [7:0]           bus_number,
    input  logic [4:0]           dev_number,
    input  logic [2:0]           func_number,
    // TLP out
    output logic                 tx_valid,
    input  logic                 tx_ready,
    output pcie_ob_pkg::data_t   tx_data,
    output logic                 tx_last,
    output logic                 tlp_done
);
    import pcie_ob_pkg::*;

    tlp_state_t state;
    wr_hdr_t    hdr_q;
    logic       hdr_held;       // header taken, still short of credits
    logic       hdr_take;
    tlp_len_t   cur_len;
    tlp_len_t   len_rnd;
    fc_pd_t     need_pd;
    logic       credit_ok;
    logic       start;
    tlp_len_t   data_left;
    req_id_t    req_id;
    logic       tx_fire;

    assign hdr_ready = (state == TLP_IDLE) && !hdr_held;
    assign hdr_take  = hdr_valid && hdr_ready;

    // check the incoming header directly so DW0 can follow the next cycle
    assign cur_len   = hdr_held ? hdr_q.len : hdr.len;
    assign len_rnd   = cur_len + tlp_len_t'(3);
    assign need_pd   = fc_pd_t'(len_rnd[9:2]);     // one data credit per 4 dwords
    assign credit_ok = (fc_ph != '0) && (fc_pd >= need_pd);
    assign start     = (state == TLP_IDLE) && (hdr_take || hdr_held) && credit_ok;

    assign req_id = {bus_number, dev_number, func_number};

    always_ff @(posedge ob_clk) begin
        if (hdr_take) begin
            hdr_q <= hdr;
        end
    end

    always_ff @(posedge ob_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= TLP_IDLE;
            hdr_held  <= 1'b0;
            data_left <= '0;
        end else begin
            case (state)
                TLP_IDLE: begin
                    if (start) begin
                        state     <= TLP_DW0;
                        hdr_held  <= 1'b0;
                        data_left <= cur_len;
                    end else if (hdr_take) begin
                        hdr_held <= 1'b1;
                    end
                end
                TLP_DW0: begin
                    if (tx_ready) begin
                        state <= TLP_DW1;
                    end
                end
                TLP_DW1: begin
                    if (tx_ready) begin
                        state <= TLP_DW2;
                    end
                end
                TLP_DW2: begin
                    if (tx_ready) begin
                        state <= TLP_DATA;
                    end
                end
                TLP_DATA: begin
                    if (tx_fire) begin
                        data_left <= data_left - tlp_len_t'(1);
                        if (tx_last) begin
                            state <= TLP_IDLE;
                        end
                    end
                end
                default: state <= TLP_IDLE;
            endcase
        end
    end

    always_comb begin
        tx_valid = 1'b0;
        tx_data  = pop_data;
        tx_last  = 1'b0;
        case (state)
            TLP_DW0: begin
                tx_valid = 1'b1;
                tx_data  = {3'b010, 5'b00000, 14'd0, hdr_q.len};   // MWr, 3DW with data
            end
            TLP_DW1: begin
                tx_valid = 1'b1;
                tx_data  = {req_id, 8'd0, hdr_q.be_last, hdr_q.be_first};  // tag 0
            end
            TLP_DW2: begin
                tx_valid = 1'b1;
                tx_data  = {hdr_q.addr, 2'b00};
            end
            TLP_DATA: begin
                tx_valid = !fifo_empty;                 // stall on a late beat
                tx_last  = (data_left == tlp_len_t'(1));
            end
            default: begin
                tx_valid = 1'b0;
            end
        endcase
    end

    assign tx_fire  = tx_valid && tx_ready;
    assign pop      = tx_fire && (state == TLP_DATA);
    assign tlp_done = pop && tx_last;

    // held dword stays put until the link takes it
    a_tx_hold: assert property (@(posedge ob_clk) disable iff (!rst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
        else $error("tx dword changed while stalled");

endmodule

`default_nettype wire

//--- rtl/ob_wr_beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_ob_settings.svh"

module ob_wr_beat_fifo #(
    parameter int DEPTH_LOG2 = `OB_FIFO_AW
) (
    input  logic               ob_clk,
    input  logic               rst_n,
    input  logic               push,
    input  pcie_ob_pkg::data_t push_data,
    output logic               full,
    input  logic               pop,
    output pcie_ob_pkg::data_t pop_data,
    output logic               empty
);
    import pcie_ob_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    data_t                 mem [DEPTH];
    logic [DEPTH_LOG2:0]   wr_ptr;      // msb is the wrap bit
    logic [DEPTH_LOG2:0]   rd_ptr;
    logic [DEPTH_LOG2-1:0] wr_idx;
    logic [DEPTH_LOG2-1:0] rd_idx;

    assign wr_idx = wr_ptr[DEPTH_LOG2-1:0];
    assign rd_idx = rd_ptr[DEPTH_LOG2-1:0];

    always_ff @(posedge ob_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge ob_clk) begin
        if (push) begin
            mem[wr_idx] <= push_data;
        end
    end

    // head entry, no read latency
    assign pop_data = mem[rd_idx];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) && (wr_idx == rd_idx);

    a_no_overflow: assert property (@(posedge ob_clk) disable iff (!rst_n)
        push |-> !full)
        else $error("beat FIFO push while full");

    a_no_underflow: assert property (@(posedge ob_clk) disable iff (!rst_n)
        pop |-> !empty)
        else $error("beat FIFO pop while empty");

endmodule

`default_nettype wire

//--- rtl/ob_wr_cmd.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_ob_settings.svh"

module ob_wr_cmd (
    input  logic                  ob_clk,
    input  logic                  rst_n,
    // AXI write address
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  logic [`OB_ADDR_W-1:0] aw_addr,
    input  pcie_ob_pkg::axi_len_t aw_len,
    // AXI write data
    input  logic                  w_valid,
    output logic                  w_ready,
    input  pcie_ob_pkg::data_t    w_data,
    input  pcie_ob_pkg::be_t      w_strb,
    input  logic                  w_last,
    // AXI write response
    output logic                  b_valid,
    input  logic                  b_ready,
    output pcie_ob_pkg::axi_resp_t b_resp,
    // control and status
    input  logic                  wr_disable,
    output logic                  wr_busy,
    input  logic                  dma_en,
    // beat FIFO
    output logic                  push,
    output pcie_ob_pkg::data_t    push_data,
    input  logic                  fifo_full,
    // header to the TLP builder
    output logic                  hdr_valid,
    input  logic                  hdr_ready,
    output pcie_ob_pkg::wr_hdr_t  hdr,
    input  logic                  tlp_done
);
    import pcie_ob_pkg::*;

    cmd_state_t state;
    logic       dis_meta;
    logic       dis_sync;
    addr_dw_t   addr_q;
    axi_len_t   len_q;
    axi_len_t   beat_cnt;
    be_t        strb_first;
    be_t        strb_last;
    logic       hdr_pend;
    axi_resp_t  resp_q;
    logic       aw_fire;
    logic       w_fire;

    // wr_disable may come from another clock
    always_ff @(posedge ob_clk or negedge rst_n) begin
        if (!rst_n) begin
            dis_meta <= 1'b0;
            dis_sync <= 1'b0;
        end else begin
            dis_meta <= wr_disable;
            dis_sync <= dis_meta;
        end
    end

    assign aw_ready = (state == CMD_IDLE) && !dis_sync;
    assign aw_fire  = aw_valid && aw_ready;
    // a dropped burst never touches the FIFO
    assign w_ready  = ((state == CMD_DATA) && !fifo_full) || (state == CMD_DRAIN);
    assign w_fire   = w_valid && w_ready;

    assign push      = w_fire && (state == CMD_DATA);
    assign push_data = w_data;

    always_ff @(posedge ob_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CMD_IDLE;
            beat_cnt <= '0;
            hdr_pend <= 1'b0;
            resp_q   <= OKAY;
        end else begin
            case (state)
                CMD_IDLE: begin
                    beat_cnt <= '0;
                    if (aw_fire) begin
                        state <= dma_en ? CMD_DATA : CMD_DRAIN; // dma_en sampled here
                    end
                end
                CMD_DATA, CMD_DRAIN: begin
                    if (w_fire) begin
                        beat_cnt <= beat_cnt + axi_len_t'(1);
                        if (w_last && (state == CMD_DATA)) begin
                            state    <= CMD_WAIT;
                            hdr_pend <= 1'b1;
                        end else if (w_last) begin
                            state  <= CMD_RESP;
                            resp_q <= SLVERR;
                        end
                    end
                end
                CMD_WAIT: begin
                    if (hdr_valid && hdr_ready) begin
                        hdr_pend <= 1'b0;
                    end
                    if (tlp_done) begin
                        state  <= CMD_RESP;
                        resp_q <= OKAY;
                    end
                end
                CMD_RESP: begin
                    if (b_ready) begin
                        state <= CMD_IDLE;
                    end
                end
                default: state <= CMD_IDLE;
            endcase
        end
    end

    always_ff @(posedge ob_clk) begin
        if (aw_fire) begin
            addr_q <= aw_addr[`OB_ADDR_W-1:2];
            len_q  <= aw_len;
        end
        if (w_fire) begin
            if (beat_cnt == '0) begin
                strb_first <= w_strb;
            end
            strb_last <= w_strb;
        end
    end

    assign hdr_valid    = hdr_pend;
    assign hdr.addr     = addr_q;
    assign hdr.len      = tlp_len_t'(len_q) + tlp_len_t'(1);
    assign hdr.be_first = strb_first;
    assign hdr.be_last  = (len_q == '0) ? 4'b0000 : strb_last;  // single dword TLP

    assign b_valid = (state == CMD_RESP);
    assign b_resp  = resp_q;
    assign wr_busy = (state != CMD_IDLE);

    // master must close the burst on the beat promised by aw_len
    a_wlast_pos: assert property (@(posedge ob_clk) disable iff (!rst_n)
        w_fire |-> (w_last == (beat_cnt == len_q)))
        else $error("w_last on wrong beat, cnt %0d len %0d", beat_cnt, len_q);

endmodule

`default_nettype wire

//--- rtl/pcie_ob_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_ob_settings.svh"

module pcie_ob_bridge (
    input  logic                   ob_clk,
    input  logic                   rst_n,
    // AXI write
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  logic [`OB_ADDR_W-1:0]  aw_addr,
    input  pcie_ob_pkg::axi_len_t  aw_len,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  pcie_ob_pkg::data_t     w_data,
    input  pcie_ob_pkg::be_t       w_strb,
    input  logic                   w_last,
    output logic                   b_valid,
    input  logic                   b_ready,
    output pcie_ob_pkg::axi_resp_t b_resp,
    input  logic                   wr_disable,
    output logic                   wr_busy,
    // PCIe config and credits
    input  logic                   dma_en,
    input  logic [7:0]             bus_number,
    input  logic [4:0]             dev_number,
    input  logic [2:0]             func_number,
    input  pcie_ob_pkg::fc_ph_t    fc_ph,
    input  pcie_ob_pkg::fc_pd_t    fc_pd,
    // TLP out
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output pcie_ob_pkg::data_t     tx_data,
    output logic                   tx_last
);
    import pcie_ob_pkg::*;

    logic    push;
    data_t   push_data;
    logic    fifo_full;
    logic    pop;
    data_t   pop_data;
    logic    fifo_empty;
    logic    hdr_valid;
    logic    hdr_ready;
    wr_hdr_t hdr;
    logic    tlp_done;         // last dword gone, B may answer

    ob_wr_cmd u_cmd (
        .ob_clk     (ob_clk),
        .rst_n      (rst_n),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .aw_len     (aw_len),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .w_strb     (w_strb),
        .w_last     (w_last),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b_resp     (b_resp),
        .wr_disable (wr_disable),
        .wr_busy    (wr_busy),
        .dma_en     (dma_en),
        .push       (push),
        .push_data  (push_data),
        .fifo_full  (fifo_full),
        .hdr_valid  (hdr_valid),
        .hdr_ready  (hdr_ready),
        .hdr        (hdr),
        .tlp_done   (tlp_done)
    );

    ob_wr_beat_fifo u_fifo (
        .ob_clk    (ob_clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (fifo_full),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (fifo_empty)
    );

    ob_mwr_tlp u_tlp (
        .ob_clk      (ob_clk),
        .rst_n       (rst_n),
        .hdr_valid   (hdr_valid),
        .hdr_ready   (hdr_ready),
        .hdr         (hdr),
        .pop         (pop),
        .pop_data    (pop_data),
        .fifo_empty  (fifo_empty),
        .fc_ph       (fc_ph),
        .fc_pd       (fc_pd),
        .bus_number  (bus_number),
        .dev_number  (dev_number),
        .func_number (func_number),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_data     (tx_data),
        .tx_last     (tx_last),
        .tlp_done    (tlp_done)
    );

endmodule

`default_nettype wire

//--- rtl/pcie_ob_pkg.sv
`default_nettype none

`include "pcie_ob_settings.svh"

package pcie_ob_pkg;

    typedef logic [`OB_ADDR_W-1:2] addr_dw_t;   // dword address
    typedef logic [`OB_LEN_W-1:0]  axi_len_t;   // beats minus one
    typedef logic [`OB_DATA_W-1:0] data_t;
    typedef logic [3:0]            be_t;
    typedef logic [9:0]            tlp_len_t;   // TLP length field, dwords
    typedef logic [`OB_FCHB-1:0]   fc_ph_t;
    typedef logic [`OB_FCDB-1:0]   fc_pd_t;
    typedef logic [15:0]           req_id_t;    // bus, device, function

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // one MWr request, handed from the AXI side to the TLP side
    typedef struct packed {
        addr_dw_t addr;
        tlp_len_t len;
        be_t      be_first;
        be_t      be_last;
    } wr_hdr_t;

    typedef enum logic [2:0] {
        CMD_IDLE,
        CMD_DATA,       // taking beats into the FIFO
        CMD_DRAIN,      // taking beats and dropping them
        CMD_WAIT,
        CMD_RESP
    } cmd_state_t;

    typedef enum logic [2:0] {
        TLP_IDLE,
        TLP_DW0,
        TLP_DW1,
        TLP_DW2,
        TLP_DATA
    } tlp_state_t;

endpackage

`default_nettype wire

//--- rtl/pcie_ob_settings.svh
`ifndef PCIE_OB_SETTINGS_SVH
`define PCIE_OB_SETTINGS_SVH

// AXI side
`define OB_ADDR_W   32
`define OB_DATA_W   32
`define OB_LEN_W    4       // up to 16 beats per burst

// link partner posted credit counters
`define OB_FCHB     8
`define OB_FCDB     12

// beat FIFO depth, log2
`define OB_FIFO_AW  4

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f pcie_ob_bridge.f --top-module tb_pcie_ob_bridge -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
exit 1
